// ==== include/cp0_macros.svh ====
`ifndef CP0_MACROS_SVH
`define CP0_MACROS_SVH

// Register addresses are {rd[4:0], sel[2:0]}
`define CP0_REG_BADVADDR    8'h40   // rd 8, sel 0
`define CP0_REG_COUNT       8'h48   // rd 9, sel 0
`define CP0_REG_COMPARE     8'h58   // rd 11, sel 0
`define CP0_REG_STATUS      8'h60   // rd 12, sel 0
`define CP0_REG_CAUSE       8'h68   // rd 13, sel 0
`define CP0_REG_EPC         8'h70   // rd 14, sel 0
`define CP0_REG_PRID        8'h78   // rd 15, sel 0
`define CP0_REG_EBASE       8'h79   // rd 15, sel 1

// Fixed processor ID word
`define CP0_PRID_VALUE      32'h0000_4220

// Reset values
`define CP0_EBASE_RESET     32'h8000_0000
`define CP0_COMPARE_RESET   32'hffff_ffff

// Exception entry points
`define CP0_BEV_VECTOR      32'hbfc0_0380   // Boot-time vector
`define CP0_GENERAL_OFFSET  32'h0000_0180   // Added to EBase

`endif

// ==== rtl/cp0_exception.sv ====
`timescale 1ns/1ps

`include "cp0_macros.svh"

module cp0_exception (
    input  logic                  clk,
    input  logic                  reset,
    input  cp0_pkg::commit_t      commit,
    input  cp0_pkg::cp0_write_t   wr,
    input  logic                  eret_flush,
    input  logic [5:0]            ext_int,
    input  logic                  ti,
    output cp0_pkg::cp0_view_t    view,
    output logic                  int_req,
    output logic [31:0]           exc_vector
);

    logic                 status_bev;
    logic [7:0]           status_im;
    logic                 status_exl;
    logic                 status_ie;
    logic                 cause_bd;
    logic [1:0]           cause_ce;
    logic [7:0]           cause_ip;
    cp0_pkg::exc_code_e   cause_exc_code;
    logic [31:0]          epc;
    logic [31:0]          badvaddr;
    logic [31:0]          ebase;

    logic exc_take;         // Valid commit that raised an exception
    logic first_exc;        // Exception taken while not already at EXL
    logic status_we;
    logic cause_we;
    logic epc_we;
    logic ebase_we;

    assign exc_take  = commit.valid && commit.exc;
    assign first_exc = exc_take && !status_exl;
    assign status_we = wr.en && (wr.addr == `CP0_REG_STATUS);
    assign cause_we  = wr.en && (wr.addr == `CP0_REG_CAUSE);
    assign epc_we    = wr.en && (wr.addr == `CP0_REG_EPC);
    assign ebase_we  = wr.en && (wr.addr == `CP0_REG_EBASE);

    always_ff @(posedge clk) begin
        if (reset) begin
            status_bev <= 1'b1;
            status_im  <= 8'd0;
            status_ie  <= 1'b0;
        end else if (status_we) begin
            status_bev <= wr.data[22];
            status_im  <= wr.data[15:8];
            status_ie  <= wr.data[0];
        end
    end

    // Exception beats eret, eret beats a software write
    always_ff @(posedge clk) begin
        if (reset) begin
            status_exl <= 1'b0;
        end else if (exc_take) begin
            status_exl <= 1'b1;
        end else if (eret_flush) begin
            status_exl <= 1'b0;
        end else if (status_we) begin
            status_exl <= wr.data[1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause_bd <= 1'b0;
        end else if (first_exc) begin
            cause_bd <= commit.bd;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause_exc_code <= cp0_pkg::EXC_INT;
            cause_ce       <= 2'd0;
        end else if (exc_take) begin
            cause_exc_code <= commit.exc_code;
            if (commit.exc_code == cp0_pkg::EXC_CPU) begin
                cause_ce <= 2'd1;   // Only CP1 can be unusable here
            end
        end
    end

    // Hardware lines sampled every cycle, software bits from mtc0
    always_ff @(posedge clk) begin
        if (reset) begin
            cause_ip <= 8'd0;
        end else begin
            cause_ip[7]   <= ext_int[5] | ti;
            cause_ip[6:2] <= ext_int[4:0];
            if (cause_we) begin
                cause_ip[1:0] <= wr.data[9:8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            epc <= 32'd0;
        end else if (first_exc) begin
            epc <= commit.bd ? commit.pc - 32'd4 : commit.pc;   // Point at the branch
        end else if (epc_we) begin
            epc <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            badvaddr <= 32'd0;
        end else if (exc_take) begin
            if (commit.exc_code == cp0_pkg::EXC_ADES) begin
                badvaddr <= commit.wdata;
            end else if (commit.exc_code == cp0_pkg::EXC_ADEL) begin
                // Misaligned pc means the fetch faulted, not the load
                badvaddr <= (commit.pc[1:0] != 2'd0) ? commit.pc : commit.wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ebase <= `CP0_EBASE_RESET;
        end else if (ebase_we) begin
            ebase[29:12] <= wr.data[29:12];     // Rest is fixed
        end
    end

    assign int_req    = (|(cause_ip & status_im)) && status_ie && !status_exl;
    assign exc_vector = status_bev ? `CP0_BEV_VECTOR : ebase + `CP0_GENERAL_OFFSET;

    always_comb begin
        view            = '0;   // Timer fields filled in at the top
        view.status_bev = status_bev;
        view.im         = status_im;
        view.exl        = status_exl;
        view.ie         = status_ie;
        view.cause_bd   = cause_bd;
        view.ce         = cause_ce;
        view.ip         = cause_ip;
        view.exc_code   = cause_exc_code;
        view.epc        = epc;
        view.badvaddr   = badvaddr;
        view.ebase      = ebase;
    end

endmodule

// ==== rtl/cp0_pkg.sv ====
package cp0_pkg;

    // Kind of instruction committing to CP0
    typedef enum logic [1:0] {
        OP_NONE = 2'd0,     // Nothing for CP0
        OP_MTC0 = 2'd1,     // Register write
        OP_ERET = 2'd2      // Return from exception
    } cp0_op_e;

    // Architectural ExcCode values
    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,    // Interrupt
        EXC_ADEL = 5'd4,    // Address error on load or fetch
        EXC_ADES = 5'd5,    // Address error on store
        EXC_SYS  = 5'd8,    // Syscall
        EXC_BP   = 5'd9,    // Breakpoint
        EXC_RI   = 5'd10,   // Reserved instruction
        EXC_CPU  = 5'd11,   // Coprocessor unusable
        EXC_OV   = 5'd12,   // Arithmetic overflow
        EXC_TRAP = 5'd13    // Trap
    } exc_code_e;

    // One instruction leaving the memory stage
    typedef struct packed {
        logic        valid;
        cp0_op_e     op;
        logic        exc;       // Raised an exception
        exc_code_e   exc_code;
        logic        bd;        // Sits in a delay slot
        logic [31:0] pc;
        logic [7:0]  addr;      // {rd, sel}
        logic [31:0] wdata;     // mtc0 data or faulting data address
    } commit_t;

    // Decoded mtc0 write, shared by the timer and the exception unit
    typedef struct packed {
        logic        en;
        logic [7:0]  addr;
        logic [31:0] data;
    } cp0_write_t;

    // Register fields seen by the read mux
    typedef struct packed {
        logic        status_bev;
        logic [7:0]  im;
        logic        exl;
        logic        ie;
        logic        cause_bd;
        logic [1:0]  ce;
        logic [7:0]  ip;
        exc_code_e   exc_code;
        logic [31:0] epc;
        logic [31:0] badvaddr;
        logic [31:0] ebase;
        logic [31:0] count;     // From the timer
        logic [31:0] compare;   // From the timer
        logic        ti;        // From the timer
    } cp0_view_t;

endpackage

// ==== rtl/cp0_read_mux.sv ====
`timescale 1ns/1ps

`include "cp0_macros.svh"

module cp0_read_mux (
    input  logic [7:0]           read_addr,
    input  cp0_pkg::cp0_view_t   view,
    output logic [31:0]          read_data
);

    logic [31:0] status_word;
    logic [31:0] cause_word;

    // Status: Bev 22, IM 15:8, EXL 1, IE 0
    assign status_word = {
        9'd0,
        view.status_bev,
        6'd0,
        view.im,
        6'd0,
        view.exl,
        view.ie
    };

    // Cause: BD 31, TI 30, CE 29:28, IP 15:8, ExcCode 6:2
    assign cause_word = {
        view.cause_bd,
        view.ti,
        view.ce,
        12'd0,
        view.ip,
        1'b0,
        view.exc_code,
        2'd0
    };

    always_comb begin
        case (read_addr)
            `CP0_REG_BADVADDR: read_data = view.badvaddr;
            `CP0_REG_COUNT:    read_data = view.count;
            `CP0_REG_COMPARE:  read_data = view.compare;
            `CP0_REG_STATUS:   read_data = status_word;
            `CP0_REG_CAUSE:    read_data = cause_word;
            `CP0_REG_EPC:      read_data = view.epc;
            `CP0_REG_PRID:     read_data = `CP0_PRID_VALUE;
            `CP0_REG_EBASE:    read_data = view.ebase;
            default:           read_data = 32'd0;   // Unimplemented registers
        endcase
    end

endmodule

// ==== rtl/cp0_timer.sv ====
`timescale 1ns/1ps

`include "cp0_macros.svh"

module cp0_timer (
    input  logic                  clk,
    input  logic                  reset,
    input  cp0_pkg::cp0_write_t   wr,
    output logic [31:0]           count,
    output logic [31:0]           compare,
    output logic                  ti
);

    logic tick;             // Count runs at half the clock rate
    logic count_we;
    logic compare_we;
    logic match;

    assign count_we   = wr.en && (wr.addr == `CP0_REG_COUNT);
    assign compare_we = wr.en && (wr.addr == `CP0_REG_COMPARE);
    assign match      = (count == compare);

    always_ff @(posedge clk) begin
        if (reset) begin
            tick <= 1'b0;
        end else begin
            tick <= ~tick;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= 32'd0;
        end else if (count_we) begin
            count <= wr.data;       // Software load wins over the increment
        end else if (tick) begin
            count <= count + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compare <= `CP0_COMPARE_RESET;
        end else if (compare_we) begin
            compare <= wr.data;
        end
    end

    // Timer interrupt flag, acknowledged by rewriting Compare
    always_ff @(posedge clk) begin
        if (reset) begin
            ti <= 1'b0;
        end else if (compare_we) begin
            ti <= 1'b0;
        end else if (match) begin
            ti <= 1'b1;
        end
    end

endmodule

// ==== rtl/cp0_top.sv ====
`timescale 1ns/1ps

module cp0_top (
    input  logic                 clk,
    input  logic                 reset,
    input  cp0_pkg::commit_t     commit,
    input  logic [5:0]           ext_int,
    input  logic [7:0]           read_addr,
    output logic [31:0]          read_data,
    output logic                 eret_flush,
    output logic [31:0]          epc,
    output logic                 status_exl,
    output logic                 int_req,
    output logic [31:0]          exc_vector
);

    cp0_pkg::cp0_write_t   wr;
    cp0_pkg::cp0_view_t    exc_view;    // Everything but the timer
    cp0_pkg::cp0_view_t    full_view;
    logic [31:0]           count;
    logic [31:0]           compare;
    logic                  ti;

    // A faulting instruction never writes or returns
    always_comb begin
        wr.en   = commit.valid && (commit.op == cp0_pkg::OP_MTC0) && !commit.exc;
        wr.addr = commit.addr;
        wr.data = commit.wdata;
    end

    assign eret_flush = commit.valid && (commit.op == cp0_pkg::OP_ERET) && !commit.exc;

    cp0_timer cp0_timer_inst (
        .clk     (clk),
        .reset   (reset),
        .wr      (wr),
        .count   (count),
        .compare (compare),
        .ti      (ti)
    );

    cp0_exception cp0_exception_inst (
        .clk        (clk),
        .reset      (reset),
        .commit     (commit),
        .wr         (wr),
        .eret_flush (eret_flush),
        .ext_int    (ext_int),
        .ti         (ti),
        .view       (exc_view),
        .int_req    (int_req),
        .exc_vector (exc_vector)
    );

    always_comb begin
        full_view         = exc_view;
        full_view.count   = count;
        full_view.compare = compare;
        full_view.ti      = ti;
    end

    cp0_read_mux cp0_read_mux_inst (
        .read_addr (read_addr),
        .view      (full_view),
        .read_data (read_data)
    );

    assign epc        = exc_view.epc;
    assign status_exl = exc_view.exl;

endmodule

// ==== src.f ====
+incdir+include
rtl/cp0_pkg.sv
rtl/cp0_timer.sv
rtl/cp0_exception.sv
rtl/cp0_read_mux.sv
rtl/cp0_top.sv
tests/cp0_checker.sv
tests/cp0_tb.sv

// ==== tests/cp0_checker.sv ====
`timescale 1ns/1ps

`include "cp0_macros.svh"

module cp0_checker (
    input  logic                clk,
    input  logic                reset,
    input  cp0_pkg::commit_t    commit,
    input  logic [5:0]          ext_int,
    input  logic [7:0]          read_addr,
    input  logic [31:0]         read_data,
    input  logic                eret_flush,
    input  logic [31:0]         epc,
    input  logic                status_exl,
    input  logic                int_req,
    input  logic [31:0]         exc_vector,
    output int                  errors,
    output int                  checks
);

    // Reference copy of every kept register
    logic        m_bev, m_exl, m_ie, m_bd, m_ti, m_tick;
    logic [7:0]  m_im, m_ip;
    logic [1:0]  m_ce;
    logic [4:0]  m_exc_code;
    logic [31:0] m_epc, m_badvaddr, m_ebase, m_count, m_compare;

    logic wr_en;
    logic exc_take;
    logic do_eret;
    logic int_exp;

    assign wr_en    = commit.valid && (commit.op == cp0_pkg::OP_MTC0) && !commit.exc;
    assign exc_take = commit.valid && commit.exc;
    assign do_eret  = commit.valid && (commit.op == cp0_pkg::OP_ERET) && !commit.exc;
    assign int_exp  = (|(m_ip & m_im)) && m_ie && !m_exl;

    function automatic logic [31:0] expected_read(input logic [7:0] addr);
        case (addr)
            `CP0_REG_BADVADDR: return m_badvaddr;
            `CP0_REG_COUNT:    return m_count;
            `CP0_REG_COMPARE:  return m_compare;
            `CP0_REG_STATUS:   return {9'd0, m_bev, 6'd0, m_im, 6'd0, m_exl, m_ie};
            `CP0_REG_CAUSE:    return {m_bd, m_ti, m_ce, 12'd0, m_ip, 1'b0, m_exc_code, 2'd0};
            `CP0_REG_EPC:      return m_epc;
            `CP0_REG_PRID:     return `CP0_PRID_VALUE;
            `CP0_REG_EBASE:    return m_ebase;
            default:           return 32'd0;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    initial begin
        errors = 0;
        checks = 0;
    end

    always @(posedge clk) begin
        if (reset) begin
            m_bev      <= 1'b1;
            m_im       <= 8'd0;
            m_ie       <= 1'b0;
            m_exl      <= 1'b0;
            m_bd       <= 1'b0;
            m_ce       <= 2'd0;
            m_ip       <= 8'd0;
            m_exc_code <= 5'd0;
            m_epc      <= 32'd0;
            m_badvaddr <= 32'd0;
            m_ebase    <= `CP0_EBASE_RESET;
            m_count    <= 32'd0;
            m_compare  <= `CP0_COMPARE_RESET;
            m_ti       <= 1'b0;
            m_tick     <= 1'b0;
        end else begin
            // Outputs seen just before the edge, against the old model state
            check_value("read_data", read_data, expected_read(read_addr));
            check_value("eret_flush", eret_flush, do_eret);
            check_value("epc", epc, m_epc);
            check_value("status_exl", status_exl, m_exl);
            check_value("int_req", int_req, int_exp);
            check_value("exc_vector", exc_vector,
                        m_bev ? `CP0_BEV_VECTOR : m_ebase + `CP0_GENERAL_OFFSET);

            m_tick <= ~m_tick;
            if (wr_en && commit.addr == `CP0_REG_COUNT) begin
                m_count <= commit.wdata;
            end else if (m_tick) begin
                m_count <= m_count + 32'd1;
            end
            if (wr_en && commit.addr == `CP0_REG_COMPARE) begin
                m_compare <= commit.wdata;
                m_ti      <= 1'b0;
            end else if (m_count == m_compare) begin
                m_ti <= 1'b1;
            end
            if (wr_en && commit.addr == `CP0_REG_STATUS) begin
                m_bev <= commit.wdata[22];
                m_im  <= commit.wdata[15:8];
                m_ie  <= commit.wdata[0];
            end
            if (exc_take) begin
                m_exl <= 1'b1;
            end else if (do_eret) begin
                m_exl <= 1'b0;
            end else if (wr_en && commit.addr == `CP0_REG_STATUS) begin
                m_exl <= commit.wdata[1];
            end
            if (exc_take) begin
                m_exc_code <= commit.exc_code;
                if (commit.exc_code == cp0_pkg::EXC_CPU) begin
                    m_ce <= 2'd1;
                end
                if (!m_exl) begin   // Nested exceptions keep EPC and BD
                    m_bd  <= commit.bd;
                    m_epc <= commit.bd ? commit.pc - 32'd4 : commit.pc;
                end
                if (commit.exc_code == cp0_pkg::EXC_ADES) begin
                    m_badvaddr <= commit.wdata;
                end else if (commit.exc_code == cp0_pkg::EXC_ADEL) begin
                    m_badvaddr <= (commit.pc[1:0] != 2'd0) ? commit.pc : commit.wdata;
                end
            end else if (wr_en && commit.addr == `CP0_REG_EPC) begin
                m_epc <= commit.wdata;
            end
            m_ip[7]   <= ext_int[5] | m_ti;
            m_ip[6:2] <= ext_int[4:0];
            if (wr_en && commit.addr == `CP0_REG_CAUSE) begin
                m_ip[1:0] <= commit.wdata[9:8];
            end
            if (wr_en && commit.addr == `CP0_REG_EBASE) begin
                m_ebase <= {m_ebase[31:30], commit.wdata[29:12], m_ebase[11:0]};
            end
        end
    end

endmodule

// ==== tests/cp0_tb.sv ====
`timescale 1ns/1ps

`include "cp0_macros.svh"

module cp0_tb;

    localparam int RESET_CYCLES   = 16;
    localparam int STIM_CYCLES    = 3000;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 1000;    // Margin for reset and readback

    logic               clk;
    logic               reset;
    cp0_pkg::commit_t   commit;
    logic [5:0]         ext_int;
    logic [7:0]         read_addr;
    logic [31:0]        read_data;
    logic               eret_flush;
    logic [31:0]        epc;
    logic               status_exl;
    logic               int_req;
    logic [31:0]        exc_vector;
    int                 errors;
    int                 checks;
    int                 cycle_count;

    always #5 clk = ~clk;

    function automatic logic [7:0] addr_by_index(input int idx);
        case (idx)
            0:       return `CP0_REG_STATUS;
            1:       return `CP0_REG_CAUSE;
            2:       return `CP0_REG_EPC;
            3:       return `CP0_REG_BADVADDR;
            4:       return `CP0_REG_COUNT;
            5:       return `CP0_REG_COMPARE;
            6:       return `CP0_REG_PRID;
            7:       return `CP0_REG_EBASE;
            default: return 8'($urandom);  // Mostly unmapped
        endcase
    endfunction

    function automatic cp0_pkg::exc_code_e pick_exc_code();
        case ($urandom_range(0, 8))
            0:       return cp0_pkg::EXC_INT;
            1:       return cp0_pkg::EXC_ADEL;
            2:       return cp0_pkg::EXC_ADES;
            3:       return cp0_pkg::EXC_SYS;
            4:       return cp0_pkg::EXC_BP;
            5:       return cp0_pkg::EXC_RI;
            6:       return cp0_pkg::EXC_CPU;
            7:       return cp0_pkg::EXC_OV;
            default: return cp0_pkg::EXC_TRAP;
        endcase
    endfunction

    task automatic drive_random_commit();
        cp0_pkg::commit_t c;
        int kind;
        c = '0;
        kind = $urandom_range(0, 99);
        c.pc = $urandom;
        if ($urandom_range(0, 3) != 0) begin
            c.pc[1:0] = 2'b00;
        end
        c.bd    = 1'($urandom_range(0, 1));
        c.addr  = addr_by_index($urandom_range(0, 8));
        c.wdata = $urandom;
        if (kind < 40) begin
            c.valid = 1'b1;
            c.op    = cp0_pkg::OP_MTC0;
            // Small values so Count meets Compare now and then
            if (c.addr == `CP0_REG_COUNT) begin
                c.wdata = $urandom_range(0, 40);
            end
            if (c.addr == `CP0_REG_COMPARE) begin
                c.wdata = $urandom_range(0, 80);
            end
        end else if (kind < 58) begin
            c.valid    = ($urandom_range(0, 7) != 0);
            c.exc      = 1'b1;
            c.exc_code = pick_exc_code();
            c.op       = $urandom_range(0, 1) ? cp0_pkg::OP_MTC0 : cp0_pkg::OP_ERET;
        end else if (kind < 70) begin
            c.valid = 1'b1;
            c.op    = cp0_pkg::OP_ERET;
        end else begin
            c.valid = 1'($urandom_range(0, 1));
            if (c.valid) begin
                c.op = cp0_pkg::OP_NONE;
            end else begin
                c.op = cp0_pkg::cp0_op_e'($urandom_range(0, 2));   // Stale opcode in an empty slot
            end
        end
        commit = c;
    endtask

    cp0_top cp0_top_inst (
        .clk        (clk),
        .reset      (reset),
        .commit     (commit),
        .ext_int    (ext_int),
        .read_addr  (read_addr),
        .read_data  (read_data),
        .eret_flush (eret_flush),
        .epc        (epc),
        .status_exl (status_exl),
        .int_req    (int_req),
        .exc_vector (exc_vector)
    );

    cp0_checker cp0_checker_inst (
        .clk        (clk),
        .reset      (reset),
        .commit     (commit),
        .ext_int    (ext_int),
        .read_addr  (read_addr),
        .read_data  (read_data),
        .eret_flush (eret_flush),
        .epc        (epc),
        .status_exl (status_exl),
        .int_req    (int_req),
        .exc_vector (exc_vector),
        .errors     (errors),
        .checks     (checks)
    );

    initial begin
        int i;
        clk       = 1'b0;
        reset     = 1'b1;
        commit    = '0;
        ext_int   = 6'd0;
        read_addr = 8'd0;
        void'($urandom(3));
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        for (i = 0; i < 8; i++) begin   // Read back reset values before any commit
            read_addr = addr_by_index(i);
            @(negedge clk);
        end
        for (i = 0; i < STIM_CYCLES; i++) begin
            drive_random_commit();
            read_addr = addr_by_index($urandom_range(0, 8));
            if ($urandom_range(0, 7) == 0) begin
                ext_int = 6'($urandom);
            end
            @(negedge clk);
        end
        commit = '0;
        repeat (2) @(negedge clk);
        $display("Run complete: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule
